// File: common/csr_pkg.sv
package csr_pkg;

    // csr numbers, subset kept by this unit
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    typedef enum logic [2:0] {
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN,
        OP_EXCP
    } csr_op_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } csr_ecode_e;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [13:0] num;
        logic [31:0] wdata;
        logic [31:0] mask;      // xchg only
        logic [31:0] pc;
        logic [31:0] vaddr;     // faulting address
        csr_ecode_e  ecode;
        logic [8:0]  esubcode;
    } csr_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;     // value before the write
        logic        redirect;
        logic [31:0] redirect_pc;
    } csr_resp_t;

    // crmd bit layout, msb first
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } csr_crmd_t;

    typedef struct packed {
        logic        tcfg_we;
        logic        ticlr;
        logic [31:0] data;      // only the low TIMER_W bits reach the timer
    } csr_timer_wr_t;

    localparam csr_crmd_t CRMD_RESET = '{datm: 2'b00, datf: 2'b00, pg: 1'b0,
                                         da: 1'b1, ie: 1'b0, plv: 2'b00};

endpackage

// File: src/csr_issue.sv
`timescale 1ns/1ns

module csr_issue (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  logic                flush,
    input  csr_pkg::csr_req_t   req,
    input  logic [7:0]          hw_int,
    input  logic                ie,
    input  logic [12:0]         ecfg_lie,
    input  logic [1:0]          estat_is,
    input  logic                ti,
    output csr_pkg::csr_req_t   stage
);

    logic [12:0]       int_lines;
    logic              stage_busy;
    logic              int_pend;
    logic              take_int;
    logic              accept;
    logic              stage_valid;
    csr_pkg::csr_req_t issue_req;
    csr_pkg::csr_req_t stage_q;

    // same bit order as estat.is, ipi and bit 10 not wired
    assign int_lines = {1'b0, ti, 1'b0, hw_int, estat_is};

    // exception or ertn already in the stage
    assign stage_busy = stage_valid &&
                        (stage_q.op == csr_pkg::OP_EXCP || stage_q.op == csr_pkg::OP_ERTN);

    assign int_pend = ie && (|(int_lines & ecfg_lie)) && !stage_busy;

    // interrupt goes through even under stall
    assign take_int = int_pend && req.valid && !flush;
    assign accept   = req.valid && !flush && (!stall || int_pend);

    always_comb
    begin
        issue_req = req;
        if (take_int)
        begin
            // preempted instruction is dropped, its pc becomes era
            issue_req.op       = csr_pkg::OP_EXCP;
            issue_req.ecode    = csr_pkg::ECODE_INT;
            issue_req.esubcode = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= accept;  // flush or stall leaves the stage empty
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            stage_q <= issue_req;
        end
    end

    always_comb
    begin
        stage       = stage_q;
        stage.valid = stage_valid;
    end

    // int code only comes from the pending path
    a_no_int_ecode: assert property (
        @(posedge clk) disable iff (!rstn)
        (accept && !take_int && req.op == csr_pkg::OP_EXCP)
            |=> (stage.valid && stage.ecode != csr_pkg::ECODE_INT)
    );

endmodule

// File: src/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile #(
    parameter int TIMER_W = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_pkg::csr_req_t       stage,
    input  logic [TIMER_W-1:0]      tcfg,
    input  logic [TIMER_W-1:0]      tval,
    input  logic                    ti,
    input  logic [7:0]              hw_int,
    output csr_pkg::csr_timer_wr_t  timer_wr,
    output logic                    ie,
    output logic [12:0]             ecfg_lie,
    output logic [1:0]              estat_is,
    output csr_pkg::csr_resp_t      resp,
    output logic                    excp_flush,
    output logic                    ertn_flush,
    output csr_pkg::csr_crmd_t      crmd
);

    csr_pkg::csr_crmd_t crmd_q;
    csr_pkg::csr_crmd_t crmd_mode;
    logic [1:0]         prmd_pplv;
    logic               prmd_pie;
    logic [5:0]         estat_ecode;
    logic [8:0]         estat_esubcode;
    logic [31:0]        era;
    logic [31:0]        badv;
    logic [31:6]        eentry;
    logic [31:0]        save [4];
    logic [31:0]        tid;

    logic               is_excp;
    logic               is_ertn;
    logic               csr_we;
    logic [31:0]        rdata;
    logic [31:0]        wmask;
    logic [31:0]        wval;

    assign is_excp = stage.valid && stage.op == csr_pkg::OP_EXCP;
    assign is_ertn = stage.valid && stage.op == csr_pkg::OP_ERTN;
    assign csr_we  = stage.valid &&
                     (stage.op == csr_pkg::OP_CSRWR || stage.op == csr_pkg::OP_CSRXCHG);

    always_comb
    begin
        rdata = '0;  // unlisted numbers read 0
        case (stage.num)
            csr_pkg::CSR_CRMD:   rdata = {23'b0, crmd_q};
            csr_pkg::CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   rdata = {19'b0, ecfg_lie};
            csr_pkg::CSR_ESTAT:
                rdata = {1'b0, estat_esubcode, estat_ecode, 3'b0,
                         1'b0, ti, 1'b0, hw_int, estat_is};
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = {eentry, 6'b0};
            csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3:
                rdata = save[stage.num[1:0]];
            csr_pkg::CSR_TID:    rdata = tid;
            csr_pkg::CSR_TCFG:   rdata[TIMER_W-1:0] = tcfg;
            csr_pkg::CSR_TVAL:   rdata[TIMER_W-1:0] = tval;
            default:             rdata = '0;
        endcase
    end

    assign wmask = (stage.op == csr_pkg::OP_CSRXCHG) ? stage.mask : '1;
    assign wval  = (rdata & ~wmask) | (stage.wdata & wmask);

    assign timer_wr.tcfg_we = csr_we && stage.num == csr_pkg::CSR_TCFG;
    assign timer_wr.ticlr   = csr_we && stage.num == csr_pkg::CSR_TICLR && wval[0];
    assign timer_wr.data    = wval;

    // flush cycle already shows the mode being entered
    always_comb
    begin
        crmd_mode = crmd_q;
        if (is_excp)
        begin
            crmd_mode.plv = 2'b00;
            crmd_mode.ie  = 1'b0;
        end
        else if (is_ertn)
        begin
            crmd_mode.plv = prmd_pplv;
            crmd_mode.ie  = prmd_pie;
        end
    end

    assign crmd       = crmd_mode;
    assign ie         = crmd_q.ie;
    assign excp_flush = is_excp;
    assign ertn_flush = is_ertn;

    always_comb
    begin
        resp          = '0;
        resp.done     = stage.valid;
        resp.rdata    = rdata;
        resp.redirect = is_excp || is_ertn;
        if (is_excp)
            resp.redirect_pc = {eentry, 6'b0};
        else if (is_ertn)
            resp.redirect_pc = era;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q         <= csr_pkg::CRMD_RESET;
            prmd_pplv      <= 2'b00;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry         <= '0;
            tid            <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
        end
        else if (is_excp)
        begin
            crmd_q         <= crmd_mode;
            prmd_pplv      <= crmd_q.plv;
            prmd_pie       <= crmd_q.ie;
            estat_ecode    <= stage.ecode;
            estat_esubcode <= stage.esubcode;
            era            <= stage.pc;
            if (stage.ecode == csr_pkg::ECODE_ALE || stage.ecode == csr_pkg::ECODE_ADE)
                badv <= stage.vaddr;
        end
        else if (is_ertn)
        begin
            crmd_q <= crmd_mode;
        end
        else if (csr_we)
        begin
            case (stage.num)
                csr_pkg::CSR_CRMD:
                begin
                    crmd_q.plv  <= wval[1:0];
                    crmd_q.ie   <= wval[2];
                    crmd_q.datf <= wval[6:5];
                    crmd_q.datm <= wval[8:7];
                    if (wval[3] ^ wval[4])  // da and pg one-hot only
                    begin
                        crmd_q.da <= wval[3];
                        crmd_q.pg <= wval[4];
                    end
                end
                csr_pkg::CSR_PRMD:
                begin
                    prmd_pplv <= wval[1:0];
                    prmd_pie  <= wval[2];
                end
                csr_pkg::CSR_ECFG:   ecfg_lie <= {1'b0, wval[11], 1'b0, wval[9:0]};
                csr_pkg::CSR_ESTAT:  estat_is <= wval[1:0];  // sw bits only
                csr_pkg::CSR_ERA:    era <= wval;
                csr_pkg::CSR_BADV:   badv <= wval;
                csr_pkg::CSR_EENTRY: eentry <= wval[31:6];
                csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
                csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3:
                    save[stage.num[1:0]] <= wval;
                csr_pkg::CSR_TID:    tid <= wval;
                default:             ;
            endcase
        end
    end

    a_flush_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush)
    );

    // no interrupt can follow straight after an exception entry
    a_excp_masks_ie: assert property (
        @(posedge clk) disable iff (!rstn)
        excp_flush |=> !(excp_flush && stage.ecode == csr_pkg::ECODE_INT)
    );

endmodule

// File: src/csr_timer.sv
`timescale 1ns/1ns

module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_pkg::csr_timer_wr_t  timer_wr,
    output logic [TIMER_W-1:0]      tcfg,
    output logic [TIMER_W-1:0]      tval,
    output logic                    ti
);

    logic               tcfg_new;  // tval load due on this edge
    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [TIMER_W-1:0] init_val;

    assign tcfg_en       = tcfg[0];
    assign tcfg_periodic = tcfg[1];
    assign init_val      = {tcfg[TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg     <= '0;
            tcfg_new <= 1'b0;
            tval     <= '0;
            ti       <= 1'b0;
        end
        else
        begin
            tcfg_new <= timer_wr.tcfg_we;
            if (timer_wr.tcfg_we)
                tcfg <= timer_wr.data[TIMER_W-1:0];

            if (tcfg_en && (tcfg_new || (tval == '0 && tcfg_periodic)))
                tval <= init_val;
            else if (!tcfg_en)
                tval <= '0;
            else if (tval != '1)
                tval <= tval - 1'b1;  // one-shot parks at all ones

            if (timer_wr.ticlr)
                ti <= 1'b0;
            else if (tcfg_en && !tcfg_new && tval == '0)
                ti <= 1'b1;
        end
    end

    a_ti_needs_en: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(ti) |-> $past(tcfg_en)
    );

endmodule

// File: src/csr_unit.sv
`timescale 1ns/1ns

module csr_unit #(
    parameter int TIMER_W = 32
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic                  flush,
    input  csr_pkg::csr_req_t     req,
    input  logic [7:0]            hw_int,
    output csr_pkg::csr_resp_t    resp,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output csr_pkg::csr_crmd_t    crmd
);

    csr_pkg::csr_req_t      stage;
    csr_pkg::csr_timer_wr_t timer_wr;
    logic                   ie;
    logic [12:0]            ecfg_lie;
    logic [1:0]             estat_is;
    logic                   ti;
    logic [TIMER_W-1:0]     tcfg;
    logic [TIMER_W-1:0]     tval;

    csr_issue u_issue (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .flush    (flush),
        .req      (req),
        .hw_int   (hw_int),
        .ie       (ie),
        .ecfg_lie (ecfg_lie),
        .estat_is (estat_is),
        .ti       (ti),
        .stage    (stage)
    );

    csr_regfile #(.TIMER_W(TIMER_W)) u_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .stage      (stage),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti         (ti),
        .hw_int     (hw_int),
        .timer_wr   (timer_wr),
        .ie         (ie),
        .ecfg_lie   (ecfg_lie),
        .estat_is   (estat_is),
        .resp       (resp),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    csr_timer #(.TIMER_W(TIMER_W)) u_timer (
        .clk      (clk),
        .rstn     (rstn),
        .timer_wr (timer_wr),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti)
    );

endmodule

// File: tb/csr_tb_tests.svh
task automatic expect_no_redirect(input string name);
    check({name, " flush"}, 32'h0, {30'b0, got_excp, got_ertn});
    check({name, " redirect"}, 32'h0, {31'b0, got.redirect});
endtask

task automatic reset_values();
    read_csr(csr_pkg::CSR_CRMD, "reset crmd");
    check("reset crmd", 32'h0000_0008, got.rdata);  // da only
    expect_no_redirect("reset crmd");
    read_csr(csr_pkg::CSR_ECFG, "reset ecfg");
    check("reset ecfg", 32'h0, got.rdata);
    expect_no_redirect("reset ecfg");
    read_csr(csr_pkg::CSR_ESTAT, "reset estat");
    check("reset estat", 32'h0, got.rdata);
    expect_no_redirect("reset estat");
    read_csr(csr_pkg::CSR_TCFG, "reset tcfg");
    check("reset tcfg", 32'h0, got.rdata);
    expect_no_redirect("reset tcfg");
endtask

task automatic round_trip();
    logic [31:0] val;
    logic [13:0] num;
    for (int i = 0; i < 5; i++)
    begin
        num = (i < 4) ? csr_pkg::CSR_SAVE0 + i[13:0] : csr_pkg::CSR_TID;
        val = $random(seed);
        write_csr(num, val, "round_trip write");
        check("round_trip write old", save_model[i], got.rdata);
        save_model[i] = val;
        read_csr(num, "round_trip read");  // next cycle, no gap
        check("round_trip read", val, got.rdata);
    end
endtask

task automatic masked_exchange();
    logic [31:0] data;
    logic [31:0] mask;
    logic [31:0] old;
    data = $random(seed);
    mask = $random(seed);
    old  = save_model[1];
    issue(make_req(csr_pkg::OP_CSRXCHG, csr_pkg::CSR_SAVE1, data, mask), "xchg save1");
    check("xchg save1 old", old, got.rdata);
    save_model[1] = (old & ~mask) | (data & mask);
    read_csr(csr_pkg::CSR_SAVE1, "xchg save1 read");
    check("xchg save1 read", save_model[1], got.rdata);

    // da and pg both set is not one-hot so da stays 1 and pg 0
    write_csr(csr_pkg::CSR_CRMD, 32'hffff_ffff, "crmd write");
    check("crmd write old", 32'h0000_0008, got.rdata);
    read_csr(csr_pkg::CSR_CRMD, "crmd fields");
    check("crmd fields", 32'h0000_01ef, got.rdata);
    write_csr(csr_pkg::CSR_CRMD, 32'h0000_0008, "crmd restore");
endtask

task automatic excp_and_return();
    csr_pkg::csr_req_t rq;
    logic [31:0]       pc;
    logic [31:0]       vaddr;
    pc    = $random(seed) & 32'hffff_fffc;
    vaddr = $random(seed);
    write_csr(csr_pkg::CSR_EENTRY, 32'h1c00_803f, "eentry write");
    read_csr(csr_pkg::CSR_EENTRY, "eentry read");
    check("eentry read", 32'h1c00_8000, got.rdata);  // low 6 bits not kept
    write_csr(csr_pkg::CSR_CRMD, 32'h0000_000f, "crmd plv3 ie");

    rq       = make_req(csr_pkg::OP_EXCP, 14'h0, 32'h0, 32'h0);
    rq.pc    = pc;
    rq.vaddr = vaddr;
    rq.ecode = csr_pkg::ECODE_ALE;
    issue(rq, "excp ale");
    check("excp flush", 32'h1, {31'b0, got_excp});
    check("excp no ertn", 32'h0, {31'b0, got_ertn});
    check("excp redirect", 32'h1, {31'b0, got.redirect});
    check("excp target", 32'h1c00_8000, got.redirect_pc);
    check("excp crmd", 32'h0000_0008, {23'b0, got_crmd});

    read_csr(csr_pkg::CSR_ESTAT, "excp estat");
    check("excp estat", 32'h0009_0000, got.rdata);  // ale in ecode field
    read_csr(csr_pkg::CSR_ERA, "excp era");
    check("excp era", pc, got.rdata);
    read_csr(csr_pkg::CSR_BADV, "excp badv");
    check("excp badv", vaddr, got.rdata);
    read_csr(csr_pkg::CSR_PRMD, "excp prmd");
    check("excp prmd", 32'h0000_0007, got.rdata);

    issue(make_req(csr_pkg::OP_ERTN, 14'h0, 32'h0, 32'h0), "ertn");
    check("ertn flush", 32'h1, {31'b0, got_ertn});
    check("ertn no excp", 32'h0, {31'b0, got_excp});
    check("ertn redirect", 32'h1, {31'b0, got.redirect});
    check("ertn target", pc, got.redirect_pc);
    check("ertn crmd", 32'h0000_000f, {23'b0, got_crmd});
endtask

task automatic timer_interrupt();
    csr_pkg::csr_req_t held;
    logic [31:0]       tcfg_val;
    int                n;
    int                min_wait;
    tcfg_val = (32'd4 << 2) | 32'h1;  // one-shot, enabled
    // land at 1, load at 2, zero after the countdown, ti one edge later, then accept
    min_wait = (4 << 2) + 4;
    write_csr(csr_pkg::CSR_ECFG, 32'h0000_0800, "ecfg lie ti");
    write_csr(csr_pkg::CSR_CRMD, 32'h0000_000c, "crmd ie");
    write_csr(csr_pkg::CSR_TCFG, tcfg_val, "tcfg one-shot");

    held    = make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_SAVE0, 32'h0, 32'h0);
    held.pc = 32'h1c00_2000;
    req     = held;
    stall   = 1'b1;  // only the interrupt may get through
    @(posedge clk);
    #2;
    n = 1;
    while (!resp.done && n < TIMEOUT)
    begin
        @(posedge clk);
        #2;
        n++;
    end
    assert (resp.done)
    else
    begin
        $display("[ERROR] timer_interrupt: no interrupt within %0d cycles", TIMEOUT);
        abort_run();
    end
    assert (n >= min_wait)
    else
    begin
        $display("[ERROR] timer_interrupt: expected at least %0d cycles, actual %0d", min_wait, n);
        abort_run();
    end
    check("timer int flush", 32'h1, {31'b0, excp_flush});
    check("timer int redirect", 32'h1, {31'b0, resp.redirect});
    check("timer int target", 32'h1c00_8000, resp.redirect_pc);
    req.valid = 1'b0;
    stall     = 1'b0;

    read_csr(csr_pkg::CSR_ESTAT, "timer estat");
    check("timer estat", 32'h0000_0800, got.rdata);  // ecode int, ti set
    read_csr(csr_pkg::CSR_ERA, "timer era");
    check("timer era", 32'h1c00_2000, got.rdata);
    write_csr(csr_pkg::CSR_TICLR, 32'h0000_0001, "ticlr");
    read_csr(csr_pkg::CSR_ESTAT, "ticlr estat");
    check("ticlr estat", 32'h0, got.rdata);
    write_csr(csr_pkg::CSR_TCFG, 32'h0, "tcfg off");
    write_csr(csr_pkg::CSR_ECFG, 32'h0, "ecfg off");
endtask

task automatic stall_and_flush();
    logic [31:0] val;
    val   = $random(seed);
    req   = make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_SAVE2, val, 32'h0);
    stall = 1'b1;
    quiet_window("stall_and_flush stall", 8);
    req.valid = 1'b0;
    stall     = 1'b0;

    req   = make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_SAVE2, val, 32'h0);
    flush = 1'b1;
    quiet_window("stall_and_flush flush", 8);
    req.valid = 1'b0;
    flush     = 1'b0;

    read_csr(csr_pkg::CSR_SAVE2, "blocked save2");
    check("blocked save2", save_model[2], got.rdata);
    write_csr(csr_pkg::CSR_SAVE2, val, "released write");
    check("released write old", save_model[2], got.rdata);
    save_model[2] = val;
    read_csr(csr_pkg::CSR_SAVE2, "released read");
    check("released read", val, got.rdata);
endtask

// File: tb/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;

    localparam int TIMEOUT = 64;  // cycles allowed per wait

    logic                   clk = 1'b0;
    logic                   rstn;
    logic                   stall;
    logic                   flush;
    csr_pkg::csr_req_t      req;
    logic [7:0]             hw_int;
    csr_pkg::csr_resp_t     resp;
    logic                   excp_flush;
    logic                   ertn_flush;
    csr_pkg::csr_crmd_t     crmd;

    // outputs captured in the done cycle
    csr_pkg::csr_resp_t     got;
    logic                   got_excp;
    logic                   got_ertn;
    csr_pkg::csr_crmd_t     got_crmd;

    integer                 seed = 32'hb8bc_0f2e;
    logic [31:0]            save_model [5];  // save0-3, then tid

    csr_unit #(.TIMER_W(32)) dut (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .hw_int     (hw_int),
        .resp       (resp),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_op_e op,
                                                   input logic [13:0] num,
                                                   input logic [31:0] wdata,
                                                   input logic [31:0] mask);
        csr_pkg::csr_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.op    = op;
        r.num   = num;
        r.wdata = wdata;
        r.mask  = mask;
        r.ecode = csr_pkg::ECODE_SYS;
        return r;
    endfunction

    // drive one request, wait for its done pulse
    task automatic issue(input csr_pkg::csr_req_t rq, input string name);
        int n;
        req = rq;
        @(posedge clk);
        #2;
        n = 1;
        while (!resp.done && n < TIMEOUT)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        req.valid = 1'b0;
        assert (resp.done)
        else
        begin
            $display("[ERROR] %s: no done pulse within %0d cycles", name, TIMEOUT);
            abort_run();
        end
        got      = resp;
        got_excp = excp_flush;
        got_ertn = ertn_flush;
        got_crmd = crmd;
    endtask

    task automatic read_csr(input logic [13:0] num, input string name);
        issue(make_req(csr_pkg::OP_CSRRD, num, 32'h0, 32'h0), name);
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data, input string name);
        issue(make_req(csr_pkg::OP_CSRWR, num, data, 32'h0), name);
    endtask

    // blocked request must not complete
    task automatic quiet_window(input string name, input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            #2;
            assert (!resp.done)
            else
            begin
                $display("[ERROR] %s: done pulse while the request was blocked", name);
                abort_run();
            end
        end
    endtask

    `include "csr_tb_tests.svh"

    initial
    begin
        rstn   = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        req    = '0;
        hw_int = 8'h00;
        for (int i = 0; i < 5; i++)
            save_model[i] = 32'h0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        reset_values();
        round_trip();
        masked_exchange();
        excp_and_return();
        timer_interrupt();
        stall_and_flush();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: all.f
+incdir+tb
common/csr_pkg.sv
src/csr_issue.sv
src/csr_regfile.sv
src/csr_timer.sv
src/csr_unit.sv
tb/csr_tb.sv
